/* fp16_sqrt.f */
verilog/fp16_pkg.sv
verilog/sqrt_pkg.sv
verilog/fp16_special_path.sv
verilog/fp16_root_datapath.sv
verilog/fp16_result_packer.sv
verilog/fp16_sqrt_unit.sv
tests/fp16_sqrt_tb.sv

/* tests/fp16_sqrt_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module fp16_sqrt_tb import fp16_pkg::*; ();

    localparam int num_tests       = 7 + 8 + 5 + 40 + 3 + 8 + 1;
    localparam int watchdog_cycles = num_tests * 14 + 100;

    logic       clk;
    logic       reset;
    logic       start;
    fp16_word_t operand;
    logic       busy;
    logic       done;
    fp16_word_t result;

    logic        fresh_start;         // marks a start that must be accepted
    logic [15:0] expected_word;
    logic [15:0] current_operand;
    int          exp_latency;
    logic        expect_busy;
    int          since_start;
    logic [31:0] rng_state;

    fp16_sqrt_unit DUT (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .operand (operand),
        .busy    (busy),
        .done    (done),
        .result  (result)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int int_sqrt(input int v);
        int r;
        r = 0;
        while ((r + 1) * (r + 1) <= v) begin
            r = r + 1;
        end
        return r;
    endfunction

    // zeros, inf, nan and every negative value bypass the root loop
    function automatic logic is_special_operand(input logic [15:0] x);
        return (x[14:0] == 15'd0) || (x[14:10] == 5'h1F) || x[15];
    endfunction

    function automatic logic [15:0] sqrt_model(input logic [15:0] x);
        logic [4:0]  ef;
        logic [9:0]  ff;
        logic [21:0] m;
        int          e;
        int          r;
        ef = x[14:10];
        ff = x[9:0];
        if (ef == 5'd0 && ff == 10'd0) return x;   // signed zero passes through
        if (ef == 5'h1F && ff != 10'd0) return nan_word;
        if (x[15]) return nan_word;
        if (ef == 5'h1F) return pinf_word;
        if (ef != 5'd0) begin
            m = {11'd0, 1'b1, ff};
            e = int'(ef) - 15;
        end else begin
            m = {12'd0, ff};
            e = -14;
            while (!m[10]) begin                   // subnormal, find the leading one
                m = m << 1;
                e = e - 1;
            end
        end
        if (e % 2 != 0) begin
            m = m << 1;
            e = e - 1;
        end
        r = int_sqrt(int'(m) << 10);
        return {1'b0, 5'(e / 2 + 15), 10'(r)};
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic report_failure(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "run aborted");
    endtask

    // cycles since the last accepted start, 0 before the first one
    always @(posedge clk) begin
        if (reset) begin
            since_start <= 0;
        end else if (fresh_start) begin
            since_start <= 1;
        end else if (since_start != 0) begin
            since_start <= since_start + 1;
        end
    end

    a_idle_after_reset : assert property (
        @(posedge clk) disable iff (reset)
        since_start == 0 |-> !busy && !done && result.raw == 16'h0000
    ) else report_failure("outputs not idle after reset");

    a_result : assert property (
        @(posedge clk) disable iff (reset) done |-> result.raw == expected_word
    ) else report_failure($sformatf("operand %h gave %h, expected %h",
        $sampled(current_operand), $sampled(result.raw), $sampled(expected_word)));

    a_latency : assert property (
        @(posedge clk) disable iff (reset) done |-> since_start == exp_latency
    ) else report_failure($sformatf("done after %0d cycles, expected %0d",
        $sampled(since_start), $sampled(exp_latency)));

    // busy spans the eleven iterations of a computed operand only
    a_busy_window : assert property (
        @(posedge clk) disable iff (reset)
        !fresh_start && since_start != 0 |-> busy == (expect_busy && since_start <= 11)
    ) else report_failure($sformatf("busy %b at cycle %0d of operand %h",
        $sampled(busy), $sampled(since_start), $sampled(current_operand)));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic launch(input logic [15:0] x);
        logic special;
        special = is_special_operand(x);
        @(posedge clk);
        start           <= 1'b1;
        fresh_start     <= 1'b1;
        operand.raw     <= x;
        current_operand <= x;
        expected_word   <= sqrt_model(x);
        exp_latency     <= special ? 2 : 12;   // specials pass two registers
        expect_busy     <= !special;
        @(posedge clk);
        start       <= 1'b0;
        fresh_start <= 1'b0;
    endtask

    task automatic wait_for_done();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n = n + 1;
            if (n > 40) abort_run("no done pulse within 40 cycles of a start");
        end while (done !== 1'b1);
    endtask

    task automatic run_op(input logic [15:0] x);
        launch(x);
        wait_for_done();
    endtask

    // two stray starts land in the middle of a computation
    task automatic run_with_ignored_start(input logic [15:0] x);
        launch(x);
        repeat (2) @(posedge clk);
        start       <= 1'b1;
        operand.raw <= 16'hBC00;               // -1.0, would be special
        @(posedge clk);
        start <= 1'b0;
        repeat (2) @(posedge clk);
        start       <= 1'b1;
        operand.raw <= 16'h4900;               // 10.0, would be computed
        @(posedge clk);
        start <= 1'b0;
        wait_for_done();
    endtask

    initial begin : stimulus
        logic [15:0] w;
        reset           = 1'b1;
        start           = 1'b0;
        operand         = '0;
        fresh_start     = 1'b0;
        expected_word   = 16'h0000;
        current_operand = 16'h0000;
        exp_latency     = 0;
        expect_busy     = 1'b0;
        rng_state       = 32'd78290;

        repeat (16) @(posedge clk);
        reset <= 1'b0;
        repeat (4) @(posedge clk);             // idle outputs checked here

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // specials
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        run_op(16'h0000);
        run_op(16'h8000);
        run_op(16'h7C00);
        run_op(16'hFC00);
        run_op(16'h7E00);                      // quiet nan
        run_op(16'h7C01);                      // signalling nan
        run_op(16'hFD55);
        for (int i = 0; i < 8; i++) begin
            rng_state = xorshift32(rng_state);
            w = {1'b1, 5'(rng_state[14:10] % 31), rng_state[9:0]};
            if (w[14:0] == 15'd0) w[0] = 1'b1;
            run_op(w);
        end

        // normal operands, odd and even exponents
        run_op(16'h3C00);
        run_op(16'h4000);
        run_op(16'h4400);
        run_op(16'h7BFF);                      // largest normal
        run_op(16'h0400);                      // smallest normal
        for (int i = 0; i < 40; i++) begin
            rng_state = xorshift32(rng_state);
            w = {1'b0, 5'(1 + rng_state[14:10] % 30), rng_state[9:0]};
            if (rng_state[31]) @(posedge clk);
            run_op(w);
        end

        // subnormals
        run_op(16'h0001);
        run_op(16'h03FF);
        run_op(16'h0200);
        for (int i = 0; i < 8; i++) begin
            rng_state = xorshift32(rng_state);
            w = {6'b000000, rng_state[9:0]};
            if (w == 16'h0000) w = 16'h0001;
            run_op(w);
        end

        run_with_ignored_start(16'h4A40);

        repeat (3) @(posedge clk);
        $display("Simulation PASSED");
        $finish;
    end

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clk);
        abort_run($sformatf("timeout: tests did not finish in %0d cycles", watchdog_cycles));
    end

endmodule

`default_nettype wire

/* verilog/fp16_pkg.sv */
`default_nettype none

package fp16_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // binary16 field layout
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int exp_w    = 5;
    localparam int frac_w   = 10;
    localparam int word_w   = 1 + exp_w + frac_w;
    localparam int exp_bias = 15;

    localparam logic [exp_w-1:0] exp_max = '1;     // inf / nan exponent code

    typedef struct packed {
        logic              sign;
        logic [exp_w-1:0]  exp;
        logic [frac_w-1:0] frac;
    } fp16_fields_t;

    // raw view for constants and output, field view for decode
    typedef union packed {
        logic [word_w-1:0] raw;
        fp16_fields_t      fields;
    } fp16_word_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fixed result patterns
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam logic [word_w-1:0] nan_word  = 16'hFE00;  // canonical nan, sign set
    localparam logic [word_w-1:0] pinf_word = 16'h7C00;

    // unbiased exponent, wide enough for subnormal normalization
    typedef logic signed [exp_w+1:0] sexp_t;

    // mantissa with hidden bit
    typedef logic [frac_w:0] mant_t;

endpackage

`default_nettype wire

/* verilog/fp16_result_packer.sv */
`timescale 1ns/1ns
`default_nettype none

module fp16_result_packer import fp16_pkg::*, sqrt_pkg::*; (
    input  wire             clk,
    input  wire             reset,
    input  wire             special_done,
    input  wire fp16_word_t special_word,
    input  wire             root_done,
    input  wire sexp_t      root_exp,
    input  wire root_t      root_mant,
    output fp16_word_t      result,
    output logic            done
);

    sexp_t      biased_exp;
    fp16_word_t computed;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // computed word
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // halved exponent lands in [-12, 7], always a normal code
    assign biased_exp = root_exp + sexp_t'(exp_bias);

    always_comb begin
        computed.fields.sign = 1'b0;                       // root is never negative
        computed.fields.exp  = biased_exp[exp_w-1:0];
        computed.fields.frac = root_mant[frac_w-1:0];      // hidden bit dropped
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
            done   <= 1'b0;
        end else begin
            done <= special_done | root_done;
            if (special_done) begin
                result <= special_word;
            end else if (root_done) begin
                result <= computed;
            end
        end
    end

    // busy gating upstream keeps the two sources apart
    a_single_source : assert property (
        @(posedge clk) disable iff (reset) !(special_done && root_done)
    );

endmodule

`default_nettype wire

/* verilog/fp16_root_datapath.sv */
`timescale 1ns/1ns
`default_nettype none

module fp16_root_datapath import fp16_pkg::*, sqrt_pkg::*; (
    input  wire             clk,
    input  wire             reset,
    input  wire             root_start,
    input  wire fp16_word_t operand,
    output logic            busy,
    output logic            root_done,
    output sexp_t           root_exp,
    output root_t           root_mant
);

    logic [3:0]        lz;
    mant_t             norm_mant;
    sexp_t             norm_exp;
    logic              exp_odd;
    logic [frac_w+1:0] adj_mant;
    sexp_t             adj_exp;

    radicand_t   radicand;
    remainder_t  rem;
    root_t       root;
    iter_count_t count;

    remainder_t rem_shift;
    remainder_t trial;
    remainder_t rem_step;
    logic       can_sub;
    root_t      root_step;
    logic       last_iter;

    // leading zeros of a subnormal fraction, 10 when empty
    function automatic logic [3:0] lead_zeros(input logic [frac_w-1:0] frac);
        logic [3:0] n;
        logic       found;
        n     = 4'd0;
        found = 1'b0;
        for (int i = frac_w - 1; i >= 0; i--) begin
            if (!found) begin
                if (frac[i]) begin
                    found = 1'b1;
                end else begin
                    n = n + 4'd1;
                end
            end
        end
        return n;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // normalization and exponent adjust
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign lz = lead_zeros(operand.fields.frac);

    always_comb begin
        if (operand.fields.exp != '0) begin
            norm_mant = {1'b1, operand.fields.frac};
            norm_exp  = sexp_t'({2'b00, operand.fields.exp}) - sexp_t'(exp_bias);
        end else begin
            // subnormal: move the top set bit into the hidden position
            norm_mant = {1'b0, operand.fields.frac} << (lz + 4'd1);
            norm_exp  = sexp_t'(1 - exp_bias) - sexp_t'({3'b000, lz}) - sexp_t'(1);
        end
    end

    assign exp_odd  = norm_exp[0];
    assign adj_mant = exp_odd ? {norm_mant, 1'b0} : {1'b0, norm_mant};
    assign adj_exp  = exp_odd ? norm_exp - sexp_t'(1) : norm_exp;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // restoring root step
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // bring down the next two radicand bits
    assign rem_shift = {rem[$bits(remainder_t)-3:0], radicand[$bits(radicand_t)-1 -: 2]};
    assign trial     = {root, 2'b01};         // 4*root + 1
    assign can_sub   = (rem_shift >= trial);
    assign rem_step  = can_sub ? rem_shift - trial : rem_shift;
    assign root_step = {root[$bits(root_t)-2:0], can_sub};

    assign last_iter = (count == iter_count_t'(1));

    // final step result goes straight to the packer
    assign root_done = busy & last_iter;
    assign root_mant = root_step;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // iteration control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (root_start) begin
            busy  <= 1'b1;
            count <= iter_count_t'(sqrt_iters);
        end else if (busy) begin
            count <= count - 1'b1;
            if (last_iter) begin
                busy <= 1'b0;                 // drops together with root_done
            end
        end
    end

    always_ff @(posedge clk) begin
        if (root_start) begin
            radicand <= radicand_t'(adj_mant) << frac_w;
            rem      <= '0;
            root     <= '0;
            root_exp <= adj_exp >>> 1;        // exact, exponent is even here
        end else if (busy) begin
            radicand <= radicand << 2;
            rem      <= rem_step;
            root     <= root_step;
        end
    end

    // the special path must hold off new work while the loop runs
    a_no_start_busy : assert property (
        @(posedge clk) disable iff (reset) root_start |-> !busy
    );

    // normalized radicand in [1,4) always gives a root in [1,2)
    a_root_normal : assert property (
        @(posedge clk) disable iff (reset) root_done |-> root_mant[$bits(root_t)-1]
    );

endmodule

`default_nettype wire

/* verilog/fp16_special_path.sv */
`timescale 1ns/1ns
`default_nettype none

module fp16_special_path import fp16_pkg::*; (
    input  wire             clk,
    input  wire             reset,
    input  wire             start,
    input  wire fp16_word_t operand,
    input  wire             busy,
    output logic            root_start,
    output logic            special_done,
    output fp16_word_t      special_word
);

    logic       exp_zero;
    logic       exp_ones;
    logic       frac_zero;
    logic       is_zero;
    logic       is_inf;
    logic       is_nan;
    logic       is_special;
    logic       accept;
    fp16_word_t special_next;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operand classification
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign exp_zero  = (operand.fields.exp == '0);
    assign exp_ones  = (operand.fields.exp == exp_max);
    assign frac_zero = (operand.fields.frac == '0);

    assign is_zero = exp_zero & frac_zero;
    assign is_inf  = exp_ones & frac_zero;
    assign is_nan  = exp_ones & ~frac_zero;

    // any set sign outside zero ends up here as well (neg finite, -inf)
    assign is_special = is_zero | is_inf | is_nan | operand.fields.sign;

    assign accept     = start & ~busy;        // starts during a computation are dropped
    assign root_start = accept & ~is_special;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // special results
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        if (is_zero) begin
            special_next = operand;           // sqrt(-0) stays -0
        end else if (is_inf && !operand.fields.sign) begin
            special_next = pinf_word;
        end else begin
            special_next = nan_word;          // nan in, -inf, negative numbers
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            special_done <= 1'b0;
        end else begin
            special_done <= accept & is_special;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && is_special) begin
            special_word <= special_next;
        end
    end

    // a special result and a new computation launch never overlap
    a_special_vs_root : assert property (
        @(posedge clk) disable iff (reset) !(special_done && root_start)
    );

endmodule

`default_nettype wire

/* verilog/fp16_sqrt_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module fp16_sqrt_unit import fp16_pkg::*; (
    input  wire             clk,
    input  wire             reset,
    input  wire             start,
    input  wire fp16_word_t operand,
    output wire             busy,
    output wire             done,
    output wire fp16_word_t result
);

    wire        root_start;
    wire        special_done;
    wire fp16_word_t special_word;
    wire        root_done;
    wire sexp_t root_exp;
    wire mant_t root_mant;           // root_t has the mantissa width

    // specials and start gating
    fp16_special_path u_special (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .operand      (operand),
        .busy         (busy),
        .root_start   (root_start),
        .special_done (special_done),
        .special_word (special_word)
    );

    // bit-serial root of finite positive operands
    fp16_root_datapath u_root (
        .clk        (clk),
        .reset      (reset),
        .root_start (root_start),
        .operand    (operand),
        .busy       (busy),
        .root_done  (root_done),
        .root_exp   (root_exp),
        .root_mant  (root_mant)
    );

    fp16_result_packer u_packer (
        .clk          (clk),
        .reset        (reset),
        .special_done (special_done),
        .special_word (special_word),
        .root_done    (root_done),
        .root_exp     (root_exp),
        .root_mant    (root_mant),
        .result       (result),
        .done         (done)
    );

endmodule

`default_nettype wire

/* verilog/sqrt_pkg.sv */
`default_nettype none

package sqrt_pkg;

    // one root bit per iteration
    localparam int sqrt_iters = 11;

    typedef logic [$clog2(sqrt_iters+1)-1:0] iter_count_t;

    // two radicand bits are consumed per step
    typedef logic [2*sqrt_iters-1:0] radicand_t;

    // remainder stays below twice the root plus the two new bits
    typedef logic [sqrt_iters+1:0] remainder_t;

    // same width as the mantissa with hidden bit
    typedef logic [sqrt_iters-1:0] root_t;

endpackage

`default_nettype wire
